//--- Bender.yml
package:
  name: pce_input

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pce_input_pkg.sv
      - verilog/pad_bus_if.sv
      - verilog/mouse_tracker.sv
      - verilog/pad_encoder.sv
      - verilog/port_scanner.sv
      - verilog/pce_input_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/pce_input_properties.sv
      - verif/pce_input_tb.sv

//--- sources.f
+incdir+verilog
verilog/pce_input_pkg.sv
verilog/pad_bus_if.sv
verilog/mouse_tracker.sv
verilog/pad_encoder.sv
verilog/port_scanner.sv
verilog/pce_input_top.sv
verif/pce_input_properties.sv
verif/pce_input_tb.sv

//--- verif/pce_input_properties.sv
/*
 * Concurrent assertions for the controller input path.
 * Bound into pce_input_top, all sampled on the rising edge of clk_sys.
 * Reads the scanner port and the mouse counters through the bind.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pce_input_defines.svh"

module pce_input_properties
	import pce_input_pkg::*;
(
	input wire logic                       clk_sys,
	input wire logic                       rst,
	input wire logic                       pad_clr,
	input wire nibble_t                    pad_nib,
	input wire logic                       clr,
	input wire port_idx_t                  port,
	input wire logic [1:0]                 mouse_cnt,
	input wire logic [`PCE_MOUSE_TO_W-1:0] to_cnt
);

	int fail_count = 0; // Failed assertions so far

	a_nib_cleared: assert property (@(posedge clk_sys)
		(rst || pad_clr) |=> (pad_nib == '0))
		else begin
			fail_count++;
			$error("pad_nib not zero the cycle after reset or clear");
		end

	// Port register catches up one cycle into the clear
	a_port_cleared: assert property (@(posedge clk_sys) disable iff (rst)
		clr |=> (!clr || port == '0))
		else begin
			fail_count++;
			$error("port index not zero while clear is held");
		end

	a_resync: assert property (@(posedge clk_sys) disable iff (rst)
		(&to_cnt) |-> (mouse_cnt == 2'd3))
		else begin
			fail_count++;
			$error("mouse count not 3 with timeout saturated");
		end

endmodule

bind pce_input_top pce_input_properties u_props (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.pad_clr   (pad_clr),
	.pad_nib   (pad_nib),
	.clr       (bus.clr),
	.port      (bus.port),
	.mouse_cnt (u_mouse.cnt),
	.to_cnt    (u_mouse.to_cnt)
);

`default_nettype wire

//--- verif/pce_input_tb.sv
/*
 * Testbench for the controller input path.
 * Inputs change on the falling edge, pad_nib is checked on the third
 * falling edge after each step. Joysticks come from an xorshift source.
 * The resync test alone holds pad_clr low for over 32767 cycles.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pce_input_defines.svh"

module pce_input_tb import pce_input_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 60000;
	localparam int MOUSE_TO       = (1 << `PCE_MOUSE_TO_W) - 1;

	logic         clk_sys = 1'b0;
	logic         rst;
	joy_t         joy [`PCE_NUM_PORTS];
	mouse_delta_t mouse_x, mouse_y;
	logic [1:0]   mouse_btn;
	logic         mouse_strobe, joy_swap, turbotap, buttons6, mouse_en;
	logic         pad_sel, pad_clr;
	nibble_t      pad_nib;

	// Model of the scanner and mouse state
	port_idx_t    m_port;
	logic         m_bank;
	logic [1:0]   m_cnt;
	logic [7:0]   m_pend_x, m_pend_y, m_pub_x, m_pub_y;

	logic [31:0]  rng;
	string        step_name;
	int           cycles = 0;
	event         step_ev, check_ev;

	always #2 clk_sys = ~clk_sys;

	pce_input_top dut0 (
		.clk_sys (clk_sys), .rst (rst),
		.joy_0 (joy[0]), .joy_1 (joy[1]), .joy_2 (joy[2]),
		.joy_3 (joy[3]), .joy_4 (joy[4]),
		.mouse_x (mouse_x), .mouse_y (mouse_y), .mouse_btn (mouse_btn),
		.mouse_strobe (mouse_strobe),
		.joy_swap (joy_swap), .turbotap (turbotap),
		.buttons6 (buttons6), .mouse_en (mouse_en),
		.pad_sel (pad_sel), .pad_clr (pad_clr), .pad_nib (pad_nib)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ======================================================================
	// Expected nibble from the model and the present inputs
	// ======================================================================
	function automatic nibble_t expected_nib();
		joy_t       j;
		nibble_t    mnib;
		logic [1:0] idx;
		idx = {m_bank, pad_sel};
		if (pad_clr)
			return 4'h0;
		if (m_port >= `PCE_NUM_PORTS)
			return (idx == 2'd3) ? 4'h0 : 4'hF; // Nothing plugged in
		j = joy[m_port];
		if (joy_swap && m_port < 2)
			j = joy[m_port ^ 3'd1];
		if (m_port == 0 && mouse_en) begin
			case (m_cnt)
				2'd0:    mnib = m_pub_x[7:4];
				2'd1:    mnib = m_pub_x[3:0];
				2'd2:    mnib = m_pub_y[7:4];
				default: mnib = m_pub_y[3:0];
			endcase
			return pad_sel ? mnib : ~{j[7], j[6], mouse_btn[0], mouse_btn[1]};
		end
		case (idx)
			2'd0:    return ~j[7:4];                   // Run select II I
			2'd1:    return ~{j[1], j[2], j[0], j[3]}; // Left down right up
			2'd2:    return ~j[11:8];
			default: return 4'h0;                      // Six-button ID
		endcase
	endfunction

	task automatic check_value(input string name, input nibble_t expected,
		input nibble_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "pad_nib check failed");
		end
	endtask

	always begin
		@(step_ev);
		repeat (3) @(negedge clk_sys);
		check_value(step_name, expected_nib(), pad_nib);
		-> check_ev;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk_sys) begin
		if (dut0.u_props.fail_count != 0) begin
			$display("A concurrent assertion on the DUT failed");
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failure");
		end
	end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================
	task automatic drive_lines(input logic sel, input logic clr, input string name);
		@(negedge clk_sys);
		if (clr && !pad_clr) begin // Clear pulse starts
			m_bank = buttons6 && !m_bank;
			if (m_cnt == 2'd3) begin
				m_pub_x  = m_pend_x;
				m_pub_y  = m_pend_y;
				m_pend_x = '0;
				m_pend_y = '0;
			end
			m_cnt = m_cnt + 2'd1;
		end
		if (clr)
			m_port = '0;
		else if (sel && !pad_sel && turbotap)
			m_port = m_port + 1'b1;
		pad_sel   = sel;
		pad_clr   = clr;
		step_name = name;
		-> step_ev;
		@(check_ev);
	endtask

	// Select level kept through the pulse
	task automatic pulse_clr(input string name);
		drive_lines(pad_sel, 1'b1, {name, "_clr"});
		drive_lines(pad_sel, 1'b0, name);
	endtask

	task automatic read_pad(input string name);
		drive_lines(1'b1, 1'b0, {name, "_sel_hi"});
		drive_lines(1'b0, 1'b0, {name, "_sel_lo"});
	endtask

	task automatic set_opts(input logic swap, input logic tap, input logic b6,
		input logic men);
		@(negedge clk_sys);
		joy_swap = swap;
		turbotap = tap;
		buttons6 = b6;
		mouse_en = men;
	endtask

	task automatic new_joys();
		@(negedge clk_sys);
		for (int i = 0; i < `PCE_NUM_PORTS; i++) begin
			rng    = xorshift(rng);
			joy[i] = rng[11:0];
		end
	endtask

	task automatic strobe_mouse();
		@(negedge clk_sys);
		rng          = xorshift(rng);
		mouse_x      = rng[7:0];
		mouse_y      = rng[15:8];
		mouse_btn    = rng[17:16];
		mouse_strobe = 1'b1;
		m_pend_x     = 8'd0 - mouse_x; // Console X is mirrored
		m_pend_y     = mouse_y;
		@(negedge clk_sys);
		mouse_strobe = 1'b0;
	endtask

	task automatic hold_idle(input int n);
		repeat (n) @(negedge clk_sys);
		if (n > MOUSE_TO)
			m_cnt = 2'd3;
	endtask

	initial begin
		rst = 1'b1;
		rng = 32'd90;
		for (int i = 0; i < `PCE_NUM_PORTS; i++)
			joy[i] = '0;
		mouse_x = '0;
		mouse_y = '0;
		mouse_btn = '0;
		mouse_strobe = 1'b0;
		joy_swap = 1'b0;
		turbotap = 1'b0;
		buttons6 = 1'b0;
		mouse_en = 1'b0;
		pad_sel = 1'b0;
		pad_clr = 1'b0;
		m_port = '0;
		m_bank = 1'b0;
		m_cnt = 2'd3;
		m_pend_x = '0;
		m_pend_y = '0;
		m_pub_x = '0;
		m_pub_y = '0;

		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("reset", 4'h0, pad_nib);
		rst = 1'b0;

		set_opts(1'b0, 1'b0, 1'b0, 1'b0); // Single pad, then swapped
		for (int i = 0; i < 8; i++) begin
			new_joys();
			read_pad("single");
		end
		set_opts(1'b1, 1'b0, 1'b0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			new_joys();
			read_pad("swap");
		end

		set_opts(1'b0, 1'b1, 1'b0, 1'b0); // Walk ports 0 to 6
		for (int r = 0; r < 3; r++) begin
			new_joys();
			drive_lines(1'b1, 1'b0, "tap_pre");
			pulse_clr("tap_start");
			for (int p = 0; p < 6; p++) begin
				drive_lines(1'b0, 1'b0, "tap_sel_lo");
				drive_lines(1'b1, 1'b0, "tap_sel_hi");
			end
		end

		set_opts(1'b0, 1'b0, 1'b1, 1'b0);
		for (int r = 0; r < 6; r++) begin
			new_joys();
			pulse_clr("six");
			read_pad("six");
		end

		set_opts(1'b0, 1'b0, 1'b0, 1'b1);
		pulse_clr("mouse_bank");
		while (m_cnt != 2'd3)
			pulse_clr("mouse_align");
		for (int r = 0; r < 3; r++) begin
			strobe_mouse();
			for (int k = 0; k < `PCE_MOUSE_NIBBLES; k++) begin
				pulse_clr("mouse");
				read_pad("mouse");
			end
		end

		// Break off a report, then let the timeout resync it
		strobe_mouse();
		pulse_clr("resync_a");
		pulse_clr("resync_b");
		strobe_mouse();
		hold_idle(MOUSE_TO + 200);
		for (int k = 0; k < `PCE_MOUSE_NIBBLES; k++) begin
			pulse_clr("resync");
			read_pad("resync");
		end

		repeat (4) @(negedge clk_sys);
		if (dut0.u_props.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("%0d assertion failures", dut0.u_props.fail_count);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

//--- verilog/mouse_tracker.sv
/*
 * Mouse emulation for the console's four-read protocol.
 * Each clear pulse advances one nibble; after the fourth the pending
 * deltas are published and the pending pair starts again from zero.
 * If pad_clr stays low for the whole timeout the sequence resyncs,
 * so the next clear pulse reads the X high nibble again.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pce_input_defines.svh"

module mouse_tracker
	import pce_input_pkg::*;
(
	input  wire logic   clk_sys,
	input  wire logic   rst,
	input  mouse_delta_t mouse_x,
	input  mouse_delta_t mouse_y,
	input  wire logic   mouse_strobe,
	pad_bus_if.mouse    bus
);

	localparam int CNT_W = $clog2(`PCE_MOUSE_NIBBLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PCE_MOUSE_NIBBLES - 1);

	logic [CNT_W-1:0]           cnt;
	logic [`PCE_MOUSE_TO_W-1:0] to_cnt;
	logic                       to_force;
	mouse_delta_t               pend_x, pend_y; // Collected since last publish
	mouse_delta_t               pub_x, pub_y;   // Shown to the console

	// Top bits all ones, so the count is 3 on the same edge as saturation
	assign to_force = &to_cnt[`PCE_MOUSE_TO_W-1:1];

	// ======================================================================
	// Resync timeout
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst)
			to_cnt <= '0;
		else if (bus.clr)
			to_cnt <= '0;
		else if (~&to_cnt)
			to_cnt <= to_cnt + 1'b1;
	end

	// ======================================================================
	// Nibble sequence and delta capture
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt    <= CNT_LAST;
			pend_x <= '0;
			pend_y <= '0;
			pub_x  <= '0;
			pub_y  <= '0;
		end else begin
			if (bus.clr_rise) begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_LAST) begin // Report done, take the new one
					pub_x  <= pend_x;
					pub_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end else if (to_force) begin
				cnt <= CNT_LAST;
			end

			// Console X runs the other way
			if (mouse_strobe) begin
				pend_x <= -mouse_x;
				pend_y <= mouse_y;
			end
		end
	end

	always_comb begin
		case (cnt)
			'd0:     bus.mouse_nib = pub_x[7:4];
			'd1:     bus.mouse_nib = pub_x[3:0];
			'd2:     bus.mouse_nib = pub_y[7:4];
			default: bus.mouse_nib = pub_y[3:0];
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/pad_bus_if.sv
/*
 * Internal bus between the port scanner and the two producers.
 * Plain levels and one-cycle pulses only, no handshake.
 * clr and clr_rise follow pad_clr combinationally.
 */

`timescale 1ns/1ns
`default_nettype none

interface pad_bus_if import pce_input_pkg::*; ();

	logic      clr;       // Copy of pad_clr
	logic      clr_rise;  // First cycle of pad_clr high
	port_idx_t port;      // Port the console is reading
	pad_word_t word;      // Active-low word for that port
	nibble_t   mouse_nib; // Movement nibble for the next read

	modport scanner (
		output clr, clr_rise, port,
		input  word
	);

	modport encoder (
		input  port, mouse_nib,
		output word
	);

	modport mouse (
		input  clr, clr_rise,
		output mouse_nib
	);

endinterface

`default_nettype wire

//--- verilog/pad_encoder.sv
/*
 * Builds the active-low pad word for the port being scanned.
 * Purely combinational. Joystick swap only exchanges ports 0 and 1.
 * With the mouse enabled, port 0 carries the mouse byte instead of a pad,
 * and run/select still come from the (swapped) first joystick.
 * Ports past the last pad read as all ones, as with nothing plugged in.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pce_input_defines.svh"

module pad_encoder
	import pce_input_pkg::*;
(
	input  joy_t       joy_0,
	input  joy_t       joy_1,
	input  joy_t       joy_2,
	input  joy_t       joy_3,
	input  joy_t       joy_4,
	input  wire logic [1:0] mouse_btn, // 0 left, 1 right
	input  wire logic  joy_swap,
	input  wire logic  mouse_en,
	pad_bus_if.encoder bus
);

	joy_t       joy_a, joy_b;
	joy_t       joys [`PCE_NUM_PORTS];
	logic [7:0] mouse_byte;

	// Console layout, directions as up right down left
	function automatic pad_word_t remap(input joy_t j);
		return {`PCE_SIX_BTN_ID,
			~j[11:8],
			~{j[1], j[2], j[0], j[3]},
			~j[7:4]};
	endfunction

	assign joy_a = joy_swap ? joy_1 : joy_0;
	assign joy_b = joy_swap ? joy_0 : joy_1;

	assign joys[0] = joy_a;
	assign joys[1] = joy_b;
	assign joys[2] = joy_2;
	assign joys[3] = joy_3;
	assign joys[4] = joy_4;

	// Movement nibble above run, select, left, right
	assign mouse_byte = {bus.mouse_nib,
		~{joy_a[7], joy_a[6], mouse_btn[0], mouse_btn[1]}};

	// ======================================================================
	// Port select
	// ======================================================================
	always_comb begin
		if (bus.port >= `PCE_NUM_PORTS)
			bus.word = 16'h0FFF;               // Empty tap slot
		else if (bus.port == '0 && mouse_en)
			bus.word = {mouse_byte, mouse_byte}; // Same on both banks
		else
			bus.word = remap(joys[bus.port]);
	end

endmodule

`default_nettype wire

//--- verilog/pce_input_defines.svh
/*
 * Sizing constants for the console controller input path.
 * The port index must be wide enough to count past PCE_NUM_PORTS,
 * so that the scanner can step onto the all-ones idle ports.
 * The mouse timeout runs for 2**PCE_MOUSE_TO_W - 1 cycles of clk_sys.
 */

`ifndef PCE_INPUT_DEFINES_SVH
`define PCE_INPUT_DEFINES_SVH

// ==========================================================================
// Multitap
// ==========================================================================
`define PCE_NUM_PORTS 5 // Pads behind the multitap
`define PCE_PORT_W 3    // Port index width

// ==========================================================================
// Mouse
// ==========================================================================
`define PCE_MOUSE_TO_W 15   // Resync timeout counter width
`define PCE_MOUSE_NIBBLES 4 // X high, X low, Y high, Y low

// Six-button bank select and the ID nibble shown on the high bank
`define PCE_BANK_LO 1'b0
`define PCE_BANK_HI 1'b1
`define PCE_SIX_BTN_ID 4'h0

`endif

//--- verilog/pce_input_pkg.sv
/*
 * Types shared by the controller input path.
 * Joystick words are active high as they come from the host side.
 * Pad words and nibbles are active low, as the console reads them.
 */

`default_nettype none

`include "pce_input_defines.svh"

package pce_input_pkg;

	// Joystick bits, 0..3 right left down up, 4..7 I II select run,
	// 8..11 buttons III to VI
	typedef logic [11:0] joy_t;

	// One port as seen by the console, four nibbles by {bank, select}
	typedef logic [15:0] pad_word_t;

	typedef logic [3:0] nibble_t;

	// Relative mouse movement, two's complement
	typedef logic signed [7:0] mouse_delta_t;

	typedef logic [`PCE_PORT_W-1:0] port_idx_t;

endpackage

`default_nettype wire

//--- verilog/pce_input_top.sv
/*
 * Controller input path of the console core.
 * Option levels are expected to be quasi-static; changing them in the
 * middle of a scan can give one odd read.
 * mouse_strobe is a single-cycle pulse in the clk_sys domain.
 * pad_sel and pad_clr must already be synchronous to clk_sys.
 */

`timescale 1ns/1ns
`default_nettype none

module pce_input_top
	import pce_input_pkg::*;
(
	input  wire logic   clk_sys,
	input  wire logic   rst,

	input  joy_t        joy_0,
	input  joy_t        joy_1,
	input  joy_t        joy_2,
	input  joy_t        joy_3,
	input  joy_t        joy_4,

	input  mouse_delta_t mouse_x,
	input  mouse_delta_t mouse_y,
	input  wire logic [1:0] mouse_btn,
	input  wire logic   mouse_strobe,

	input  wire logic   joy_swap,
	input  wire logic   turbotap,
	input  wire logic   buttons6,
	input  wire logic   mouse_en,

	input  wire logic   pad_sel,
	input  wire logic   pad_clr,
	output nibble_t     pad_nib
);

	pad_bus_if bus ();

	port_scanner u_scanner (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.pad_sel  (pad_sel),
		.pad_clr  (pad_clr),
		.turbotap (turbotap),
		.buttons6 (buttons6),
		.bus      (bus.scanner),
		.pad_nib  (pad_nib)
	);

	pad_encoder u_encoder (
		.joy_0     (joy_0),
		.joy_1     (joy_1),
		.joy_2     (joy_2),
		.joy_3     (joy_3),
		.joy_4     (joy_4),
		.mouse_btn (mouse_btn),
		.joy_swap  (joy_swap),
		.mouse_en  (mouse_en),
		.bus       (bus.encoder)
	);

	mouse_tracker u_mouse (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.bus          (bus.mouse)
	);

endmodule

`default_nettype wire

//--- verilog/port_scanner.sv
/*
 * Answers the console's select and clear lines.
 * Output nibble is registered, so it follows the lines one clock late,
 * and a new port shows up one clock after that.
 * The bank only changes on a clear pulse; dropping buttons6 takes
 * effect at the next clear. The port only advances with turbotap set.
 */

`timescale 1ns/1ns
`default_nettype none

`include "pce_input_defines.svh"

module port_scanner
	import pce_input_pkg::*;
(
	input  wire logic  clk_sys,
	input  wire logic  rst,
	input  wire logic  pad_sel,
	input  wire logic  pad_clr,
	input  wire logic  turbotap,
	input  wire logic  buttons6,
	pad_bus_if.scanner bus,
	output nibble_t    pad_nib
);

	logic       last_sel, last_clr;
	logic       sel_rise;
	logic       bank;
	logic [1:0] nib_idx;
	port_idx_t  port;
	nibble_t    nib_q;

	assign bus.clr      = pad_clr;
	assign bus.clr_rise = pad_clr & ~last_clr;
	assign bus.port     = port;

	assign sel_rise = pad_sel & ~last_sel;
	assign nib_idx  = {bank, pad_sel};

	// ======================================================================
	// Port counter, bank and output latch
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			last_sel <= 1'b0;
			last_clr <= 1'b0;
			port     <= '0;
			bank     <= `PCE_BANK_LO;
			nib_q    <= '0;
		end else begin
			last_sel <= pad_sel;
			last_clr <= pad_clr;
			nib_q    <= bus.word[{nib_idx, 2'b00} +: 4];

			if (pad_clr) begin
				port  <= '0;
				nib_q <= '0; // Console sees 0 while clearing
				if (bus.clr_rise)
					bank <= (bank == `PCE_BANK_LO && buttons6) ? `PCE_BANK_HI
						: `PCE_BANK_LO;
			end else if (sel_rise && turbotap) begin
				port <= port + 1'b1; // Walks past the last pad on purpose
			end
		end
	end

	assign pad_nib = nib_q;

endmodule

`default_nettype wire
